//--- rgbw_led_ctrl.f
design/rgbw_pkg.sv
design/spi_byte_receiver.sv
design/rgbw_frame_dispenser.sv
design/rgbw_colour_scaler.sv
design/rgbw_pwm.sv
design/rgbw_led_ctrl.sv
dv/rgbw_led_ctrl_properties.sv
dv/rgbw_led_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module rgbw_led_ctrl_tb -f rgbw_led_ctrl.f \
    --Mdir obj_dir -o rgbw_led_ctrl_sim > build.log 2>&1 \
    && ./obj_dir/rgbw_led_ctrl_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "ERRORS FOUND" sim.log \
    && { echo "simulation reported errors, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

//--- dv/rgbw_led_ctrl_tb.sv
/*
 * Testbench for the RGBW LED controller, SPI in and LED duty out.
 * Duty is measured by counting LED high cycles after the PWM has settled.
 * A frame cut short needs FRAME_TIMEOUT idle cycles before the next frame.
 */
`timescale 1ns/1ps

module rgbw_led_ctrl_tb;

    localparam int NUM_TESTS = 22;
    localparam int BYTE_CYCLES = 64;
    // up to two junk bytes plus select and release overhead
    localparam int FRAME_CYCLES = (rgbw_pkg::FRAME_BYTES + 2) * BYTE_CYCLES + 32;
    localparam int IDLE_CYCLES = rgbw_pkg::FRAME_TIMEOUT + 64;
    localparam int MEASURE_CYCLES = 2 * rgbw_pkg::PWM_PERIOD
        + 2 * rgbw_pkg::BLINK_PERIODS * rgbw_pkg::PWM_PERIOD;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (FRAME_CYCLES + MEASURE_CYCLES + IDLE_CYCLES)
        + 2000;

    logic clk;
    logic reset;
    logic sclk;
    logic mosi;
    logic cs_n;
    logic led_red;
    logic led_green;
    logic led_blue;
    logic led_white;

    logic [31:0] lfsr_state = 32'd78203;
    logic [63:0] active_frame = '0;
    string       test_name = "";
    int          req_count = 0;
    int          done_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          cycle_count = 0;

    rgbw_led_ctrl dut_i (
        .clk       (clk),
        .reset     (reset),
        .sclk      (sclk),
        .mosi      (mosi),
        .cs_n      (cs_n),
        .led_red   (led_red),
        .led_green (led_green),
        .led_blue  (led_blue),
        .led_white (led_white)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        value = 8'd0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // frame word holds the eight bytes in send order, first byte on top
    function automatic logic [63:0] make_frame(input logic [7:0] level, input logic [7:0] idx,
                                               input logic [7:0] r, input logic [7:0] g,
                                               input logic [7:0] b, input logic [7:0] w,
                                               input logic [7:0] mode);
        return {rgbw_pkg::SYNC_BYTE, level, idx, r, g, b, w, mode};
    endfunction

    // reference model for channel 0..3 as red, green, blue and white
    function automatic int expected_duty(input logic [63:0] frame, input int ch);
        logic [7:0]  level;
        logic [2:0]  sel;
        logic [7:0]  value;
        logic [31:0] preset;
        level = frame[55:48];
        sel = frame[42:40];
        preset = rgbw_pkg::PALETTE[sel];
        if (sel == 3'd0) begin
            value = frame[39 - 8 * ch -: 8];
        end else begin
            value = preset[31 - 8 * ch -: 8];
        end
        return (int'(value) * (int'(level) + 1)) / 256;
    endfunction

    function automatic bit is_blink(input logic [63:0] frame);
        return frame[7:0] != rgbw_pkg::MODE_OFF && frame[7:0] != rgbw_pkg::MODE_STEADY;
    endfunction

    function automatic int window_cycles(input logic [63:0] frame);
        if (is_blink(frame)) begin
            return 2 * rgbw_pkg::BLINK_PERIODS * rgbw_pkg::PWM_PERIOD;
        end
        return rgbw_pkg::PWM_PERIOD;
    endfunction

    function automatic int expected_high(input logic [63:0] frame, input int ch);
        if (frame[7:0] == rgbw_pkg::MODE_OFF) begin
            return 0;
        end else if (is_blink(frame)) begin
            return rgbw_pkg::BLINK_PERIODS * expected_duty(frame, ch);
        end
        return expected_duty(frame, ch);
    endfunction

    function automatic string channel_name(input int ch);
        case (ch)
            0: return "red";
            1: return "green";
            2: return "blue";
            default: return "white";
        endcase
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("Fail at %0t: %s expected %0d got %0d", $time, what, expected, actual);
        end
    endtask

    // one mode 0 byte where mosi changes with sclk low and a half period is 4 clk cycles
    task automatic spi_byte(input logic [7:0] value);
        for (int i = 7; i >= 0; i--) begin
            @(posedge clk);
            sclk <= 1'b0;
            mosi <= value[i];
            repeat (3) @(posedge clk);
            @(posedge clk);
            sclk <= 1'b1;
            repeat (3) @(posedge clk);
        end
    endtask

    task automatic send_frame(input logic [63:0] frame, input int nbytes, input int junk_bytes);
        logic [7:0] junk;
        @(posedge clk);
        cs_n <= 1'b0;
        sclk <= 1'b0;
        repeat (4) @(posedge clk);
        for (int j = 0; j < junk_bytes; j++) begin
            junk = random_byte();
            if (junk == rgbw_pkg::SYNC_BYTE) begin
                junk = junk ^ 8'h01;
            end
            spi_byte(junk);
        end
        for (int k = 0; k < nbytes; k++) begin
            spi_byte(frame[63 - 8 * k -: 8]);
        end
        @(posedge clk);
        sclk <= 1'b0;
        repeat (4) @(posedge clk);
        cs_n <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    // hand one measurement to the comparing process and wait for it
    task automatic measure(input string name, input logic [63:0] frame);
        active_frame = frame;
        test_name = name;
        req_count++;
        wait (done_count == req_count);
    endtask

    initial begin : compare_proc
        int hi [0:3];
        int window;
        int errors_before;
        forever begin
            wait (req_count != done_count);
            errors_before = error_count;
            window = window_cycles(active_frame);
            // let the new frame reach the pwm latch
            repeat (2 * rgbw_pkg::PWM_PERIOD) @(negedge clk);
            for (int c = 0; c < 4; c++) begin
                hi[c] = 0;
            end
            repeat (window) begin
                @(negedge clk);
                hi[0] = hi[0] + int'(led_red);
                hi[1] = hi[1] + int'(led_green);
                hi[2] = hi[2] + int'(led_blue);
                hi[3] = hi[3] + int'(led_white);
            end
            for (int c = 0; c < 4; c++) begin
                check_value($sformatf("%s %s high cycles", test_name, channel_name(c)),
                            expected_high(active_frame, c), hi[c]);
            end
            test_count++;
            if (error_count == errors_before) begin
                $display("test %s: ok", test_name);
            end else begin
                $display("test %s: mismatch", test_name);
            end
            done_count++;
        end
    end

    initial begin : stimulus
        logic [63:0] frame;
        logic [63:0] kept;
        reset = 1'b0;
        sclk = 1'b0;
        mosi = 1'b0;
        cs_n = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b1;

        measure("reset", '0);

        for (int i = 0; i < 3; i++) begin
            frame = make_frame(8'hFF, 8'h00, random_byte(), random_byte(), random_byte(),
                               random_byte(), rgbw_pkg::MODE_STEADY);
            send_frame(frame, rgbw_pkg::FRAME_BYTES, 0);
            measure($sformatf("direct_full_%0d", i), frame);
        end
        for (int i = 0; i < 3; i++) begin
            frame = make_frame(random_byte(), 8'h00, random_byte(), random_byte(),
                               random_byte(), random_byte(), rgbw_pkg::MODE_STEADY);
            send_frame(frame, rgbw_pkg::FRAME_BYTES, 0);
            measure($sformatf("direct_scaled_%0d", i), frame);
        end

        // direct bytes are random here and must be ignored
        for (int i = 1; i < 8; i++) begin
            frame = make_frame(random_byte(), 8'(i), random_byte(), random_byte(),
                               random_byte(), random_byte(), rgbw_pkg::MODE_STEADY);
            send_frame(frame, rgbw_pkg::FRAME_BYTES, 0);
            measure($sformatf("palette_%0d", i), frame);
        end
        frame = make_frame(random_byte(), 8'h0D, random_byte(), random_byte(),
                           random_byte(), random_byte(), rgbw_pkg::MODE_STEADY);
        send_frame(frame, rgbw_pkg::FRAME_BYTES, 0);
        measure("palette_high_index", frame);

        kept = frame;
        send_frame(kept, 0, 2);
        measure("junk_only", kept);
        frame = make_frame(random_byte(), 8'h00, random_byte(), random_byte(),
                           random_byte(), random_byte(), rgbw_pkg::MODE_STEADY);
        send_frame(frame, rgbw_pkg::FRAME_BYTES, 2);
        measure("junk_then_frame", frame);
        kept = frame;
        frame = make_frame(random_byte(), 8'h00, random_byte(), random_byte(),
                           random_byte(), random_byte(), rgbw_pkg::MODE_STEADY);
        send_frame(frame, 5, 0);
        // the parser drops the stalled frame after its gap timeout
        repeat (IDLE_CYCLES) @(posedge clk);
        measure("partial_frame", kept);
        frame = make_frame(random_byte(), 8'h00, random_byte(), random_byte(),
                           random_byte(), random_byte(), rgbw_pkg::MODE_STEADY);
        send_frame(frame, rgbw_pkg::FRAME_BYTES, 0);
        measure("after_partial", frame);

        frame = make_frame(8'hFF, 8'h00, random_byte(), random_byte(), random_byte(),
                           random_byte(), rgbw_pkg::MODE_OFF);
        send_frame(frame, rgbw_pkg::FRAME_BYTES, 0);
        measure("mode_off", frame);
        frame = make_frame(random_byte(), 8'h00, random_byte(), random_byte(),
                           random_byte(), random_byte(), 8'h02);
        send_frame(frame, rgbw_pkg::FRAME_BYTES, 0);
        measure("blink_direct", frame);
        frame = make_frame(random_byte(), 8'h06, random_byte(), random_byte(),
                           random_byte(), random_byte(), 8'hA7);
        send_frame(frame, rgbw_pkg::FRAME_BYTES, 0);
        measure("blink_palette", frame);

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run timed out after %0d clock cycles without finishing", cycle_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- dv/rgbw_led_ctrl_properties.sv
/*
 * Assertions on the PWM stage and the SPI receiver inside the controller.
 * Bound to the controller top and reaching the stage signals by instance name.
 */
`timescale 1ns/1ps

module rgbw_led_ctrl_properties (
    input logic       clk,
    input logic       reset,
    input logic [7:0] pwm_cnt,
    input logic [7:0] mode_q,
    input logic       led_red,
    input logic       led_green,
    input logic       led_blue,
    input logic       led_white,
    input logic       cs_n_sync,
    input logic       rx_ready
);

    logic any_led;

    assign any_led = led_red || led_green || led_blue || led_white;

    off_leds_low: assert property (@(posedge clk) disable iff (!reset)
        (mode_q == rgbw_pkg::MODE_OFF) |-> !any_led)
        else $error("an LED is high while the latched mode is off");

    counter_in_range: assert property (@(posedge clk) disable iff (!reset)
        pwm_cnt < 8'(rgbw_pkg::PWM_PERIOD))
        else $error("pwm counter reached the period length");

    // rx_ready clears one cycle after the synchronised deselect
    ready_low_deselected: assert property (@(posedge clk) disable iff (!reset)
        cs_n_sync |=> !rx_ready)
        else $error("rx_ready high while chip select is inactive");

    leds_low_after_reset: assert property (@(posedge clk) !reset |=> !any_led)
        else $error("an LED is high right after reset");

endmodule

bind rgbw_led_ctrl rgbw_led_ctrl_properties props_i (
    .clk       (clk),
    .reset     (reset),
    .pwm_cnt   (pwm_i.pwm_cnt),
    .mode_q    (pwm_i.mode_q),
    .led_red   (led_red),
    .led_green (led_green),
    .led_blue  (led_blue),
    .led_white (led_white),
    .cs_n_sync (rx_i.cs_n_sync),
    .rx_ready  (rx_ready)
);

//--- design/rgbw_led_ctrl.sv
/*
 * RGBW LED controller top: SPI receiver, frame parser, scaler, PWM.
 * Write only, no MISO. LEDs are off until the first complete frame.
 */
`timescale 1ns/1ps

module rgbw_led_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic sclk,
    input  logic mosi,
    input  logic cs_n,
    output logic led_red,
    output logic led_green,
    output logic led_blue,
    output logic led_white
);

    logic [7:0] rx_byte;
    logic       rx_ready;

    // published frame fields
    logic [7:0] intensity;
    logic [7:0] colour_idx;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic [7:0] white;
    logic [7:0] mode;

    logic [7:0] red_duty;
    logic [7:0] green_duty;
    logic [7:0] blue_duty;
    logic [7:0] white_duty;
    logic [7:0] pwm_mode;

    spi_byte_receiver rx_i (
        .clk      (clk),
        .reset    (reset),
        .sclk     (sclk),
        .mosi     (mosi),
        .cs_n     (cs_n),
        .rx_byte  (rx_byte),
        .rx_ready (rx_ready)
    );

    rgbw_frame_dispenser disp_i (
        .clk        (clk),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .rx_ready   (rx_ready),
        .intensity  (intensity),
        .colour_idx (colour_idx),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .white      (white),
        .mode       (mode)
    );

    rgbw_colour_scaler scaler_i (
        .clk        (clk),
        .reset      (reset),
        .intensity  (intensity),
        .colour_idx (colour_idx),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .white      (white),
        .mode       (mode),
        .red_duty   (red_duty),
        .green_duty (green_duty),
        .blue_duty  (blue_duty),
        .white_duty (white_duty),
        .out_mode   (pwm_mode)
    );

    rgbw_pwm pwm_i (
        .clk        (clk),
        .reset      (reset),
        .red_duty   (red_duty),
        .green_duty (green_duty),
        .blue_duty  (blue_duty),
        .white_duty (white_duty),
        .mode       (pwm_mode),
        .led_red    (led_red),
        .led_green  (led_green),
        .led_blue   (led_blue),
        .led_white  (led_white)
    );

endmodule

//--- design/rgbw_pwm.sv
/*
 * Four-channel PWM; duties and mode only take effect at the counter wrap.
 * Any mode other than off or steady blinks. The blink phase runs freely.
 */
`timescale 1ns/1ps

module rgbw_pwm (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] red_duty,
    input  logic [7:0] green_duty,
    input  logic [7:0] blue_duty,
    input  logic [7:0] white_duty,
    input  logic [7:0] mode,
    output logic       led_red,
    output logic       led_green,
    output logic       led_blue,
    output logic       led_white
);

    logic [7:0] pwm_cnt;
    logic [7:0] mode_q;
    logic [7:0] red_q;
    logic [7:0] green_q;
    logic [7:0] blue_q;
    logic [7:0] white_q;

    logic [$clog2(rgbw_pkg::BLINK_PERIODS)-1:0] blink_cnt;
    logic blink_dark;
    logic wrap;
    logic leds_on;

    assign wrap = (pwm_cnt == 8'(rgbw_pkg::PWM_PERIOD - 1));

    always_ff @(posedge clk) begin
        if (!reset) begin
            pwm_cnt    <= 8'd0;
            mode_q     <= rgbw_pkg::MODE_OFF;
            blink_cnt  <= '0;
            blink_dark <= 1'b0;
        end else if (wrap) begin
            pwm_cnt <= 8'd0;
            mode_q  <= mode;
            // count whole periods, flip the blink phase every BLINK_PERIODS
            if (blink_cnt == rgbw_pkg::BLINK_PERIODS - 1) begin
                blink_cnt  <= '0;
                blink_dark <= !blink_dark;
            end else begin
                blink_cnt <= blink_cnt + 1'b1;
            end
        end else begin
            pwm_cnt <= pwm_cnt + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (wrap) begin
            red_q   <= red_duty;
            green_q <= green_duty;
            blue_q  <= blue_duty;
            white_q <= white_duty;
        end
    end

    always_comb begin
        if (mode_q == rgbw_pkg::MODE_OFF) begin
            leds_on = 1'b0;
        end else if (mode_q == rgbw_pkg::MODE_STEADY) begin
            leds_on = 1'b1;
        end else begin
            leds_on = !blink_dark;
        end
    end

    // duty 255 stays high for the whole period since pwm_cnt tops out at 254
    assign led_red   = leds_on && (pwm_cnt < red_q);
    assign led_green = leds_on && (pwm_cnt < green_q);
    assign led_blue  = leds_on && (pwm_cnt < blue_q);
    assign led_white = leds_on && (pwm_cnt < white_q);

endmodule

//--- design/rgbw_colour_scaler.sv
/*
 * Colour source select and intensity scaling, one registered stage.
 * duty = value * (intensity + 1) / 256, truncated.
 */
`timescale 1ns/1ps

module rgbw_colour_scaler (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] intensity,
    input  logic [7:0] colour_idx,
    input  logic [7:0] red,
    input  logic [7:0] green,
    input  logic [7:0] blue,
    input  logic [7:0] white,
    input  logic [7:0] mode,
    output logic [7:0] red_duty,
    output logic [7:0] green_duty,
    output logic [7:0] blue_duty,
    output logic [7:0] white_duty,
    output logic [7:0] out_mode
);

    logic [31:0] palette_word;
    logic [31:0] src_word;

    function automatic logic [7:0] scale(input logic [7:0] value, input logic [7:0] level);
        logic [16:0] product;
        product = {9'd0, value} * ({9'd0, level} + 17'd1);
        return product[15:8];
    endfunction

    // only the low three bits select, so index 8 aliases to 0 and so on
    assign palette_word = rgbw_pkg::PALETTE[colour_idx[2:0]];

    always_comb begin
        if (colour_idx[2:0] == 3'd0) begin
            src_word = {red, green, blue, white};
        end else begin
            src_word = palette_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            red_duty   <= 8'd0;
            green_duty <= 8'd0;
            blue_duty  <= 8'd0;
            white_duty <= 8'd0;
            out_mode   <= rgbw_pkg::MODE_OFF;
        end else begin
            red_duty   <= scale(src_word[31:24], intensity);
            green_duty <= scale(src_word[23:16], intensity);
            blue_duty  <= scale(src_word[15:8], intensity);
            white_duty <= scale(src_word[7:0], intensity);
            out_mode   <= mode;
        end
    end

endmodule

//--- design/rgbw_frame_dispenser.sv
/*
 * Frame parser: sync byte, six shadowed fields, then the mode byte publishes all.
 * Bytes more than FRAME_TIMEOUT cycles apart drop the frame, so a host's
 * sclk half period must stay below FRAME_TIMEOUT/16 cycles.
 */
`timescale 1ns/1ps

module rgbw_frame_dispenser (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rx_byte,
    input  logic       rx_ready,
    output logic [7:0] intensity,
    output logic [7:0] colour_idx,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    output logic [7:0] white,
    output logic [7:0] mode
);

    logic       rdy_q;
    logic       rdy_prev;
    logic       rdy_edge;
    logic [7:0] byte_q;

    logic [$clog2(rgbw_pkg::FRAME_BYTES)-1:0]   byte_cnt;
    logic [$clog2(rgbw_pkg::FRAME_TIMEOUT)-1:0] gap_cnt;

    // shadow copies of the frame being received
    logic [7:0] intensity_sh;
    logic [7:0] colour_idx_sh;
    logic [7:0] red_sh;
    logic [7:0] green_sh;
    logic [7:0] blue_sh;
    logic [7:0] white_sh;

    always_ff @(posedge clk) begin
        if (!reset) begin
            rdy_q      <= 1'b0;
            rdy_prev   <= 1'b0;
            rdy_edge   <= 1'b0;
            byte_cnt   <= '0;
            gap_cnt    <= '0;
            intensity  <= 8'd0;
            colour_idx <= 8'd0;
            red        <= 8'd0;
            green      <= 8'd0;
            blue       <= 8'd0;
            white      <= 8'd0;
            mode       <= rgbw_pkg::MODE_OFF;
        end else begin
            rdy_q    <= rx_ready;
            rdy_prev <= rdy_q;
            rdy_edge <= rdy_q && !rdy_prev;

            if (rdy_edge) begin
                gap_cnt <= '0;
                if (byte_cnt == '0) begin
                    // anything but the sync byte is dropped here
                    if (byte_q == rgbw_pkg::SYNC_BYTE) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end else if (byte_cnt == rgbw_pkg::FRAME_BYTES - 1) begin
                    intensity  <= intensity_sh;
                    colour_idx <= colour_idx_sh;
                    red        <= red_sh;
                    green      <= green_sh;
                    blue       <= blue_sh;
                    white      <= white_sh;
                    mode       <= byte_q;
                    byte_cnt   <= '0;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end else if (byte_cnt == '0) begin
                gap_cnt <= '0;
            end else if (gap_cnt == rgbw_pkg::FRAME_TIMEOUT - 1) begin
                // stalled frame, e.g. cut short by cs_n
                byte_cnt <= '0;
                gap_cnt  <= '0;
            end else begin
                gap_cnt <= gap_cnt + 1'b1;
            end
        end
    end

    // rx_byte is stable while rx_ready is high, so byte_q is valid at rdy_edge
    always_ff @(posedge clk) begin
        byte_q <= rx_byte;
        if (rdy_edge) begin
            case (byte_cnt)
                3'd1: intensity_sh  <= byte_q;
                3'd2: colour_idx_sh <= byte_q;
                3'd3: red_sh        <= byte_q;
                3'd4: green_sh      <= byte_q;
                3'd5: blue_sh       <= byte_q;
                3'd6: white_sh      <= byte_q;
                default: ;
            endcase
        end
    end

endmodule

//--- design/spi_byte_receiver.sv
/*
 * SPI mode 0 slave, receive only, MSB first.
 * The sclk half period must be at least 4 clk cycles for the synchronisers.
 */
`timescale 1ns/1ps

module spi_byte_receiver (
    input  logic       clk,
    input  logic       reset,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       cs_n,
    output logic [7:0] rx_byte,
    output logic       rx_ready
);

    // two-flop synchronisers plus one more sclk stage for edge detection
    logic sclk_meta;
    logic sclk_sync;
    logic sclk_prev;
    logic mosi_meta;
    logic mosi_sync;
    logic cs_n_meta;
    logic cs_n_sync;

    logic [2:0] bit_cnt;
    logic [6:0] shift_reg;
    logic       sclk_rise;

    assign sclk_rise = sclk_sync && !sclk_prev;

    always_ff @(posedge clk) begin
        if (!reset) begin
            sclk_meta <= 1'b0;
            sclk_sync <= 1'b0;
            sclk_prev <= 1'b0;
            mosi_meta <= 1'b0;
            mosi_sync <= 1'b0;
            cs_n_meta <= 1'b1;
            cs_n_sync <= 1'b1;
            bit_cnt   <= 3'd0;
            rx_ready  <= 1'b0;
        end else begin
            sclk_meta <= sclk;
            sclk_sync <= sclk_meta;
            sclk_prev <= sclk_sync;
            mosi_meta <= mosi;
            mosi_sync <= mosi_meta;
            cs_n_meta <= cs_n;
            cs_n_sync <= cs_n_meta;

            if (cs_n_sync) begin
                bit_cnt  <= 3'd0;
                rx_ready <= 1'b0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                // high after the 8th bit, low again on the next byte's first edge
                rx_ready <= (bit_cnt == 3'd7);
            end
        end
    end

    // byte assembly from the synchronised mosi
    always_ff @(posedge clk) begin
        if (!cs_n_sync && sclk_rise) begin
            shift_reg <= {shift_reg[5:0], mosi_sync};
            if (bit_cnt == 3'd7) begin
                rx_byte <= {shift_reg, mosi_sync};
            end
        end
    end

endmodule

//--- design/rgbw_pkg.sv
/*
 * Shared constants for the RGBW LED controller.
 * PALETTE entries pack red, green, blue, white from the high byte down.
 * Entry 0 is never read because colour index 0 selects the direct colour.
 */
package rgbw_pkg;

    // frame layout
    localparam logic [7:0] SYNC_BYTE = 8'h55;
    localparam int FRAME_BYTES = 8;

    // a partial frame is dropped once no byte arrives for this many cycles
    localparam int FRAME_TIMEOUT = 1024;

    // preset colours, indexed by the low three bits of the colour index
    localparam logic [31:0] PALETTE [0:7] = '{
        32'h0000_0000,
        32'hFF00_0000,
        32'h00FF_0000,
        32'h0000_FF00,
        32'h0000_00FF,
        32'hFFA0_0020,
        32'h00C0_C040,
        32'hC000_A010
    };

    // pwm counter runs 0 .. PWM_PERIOD-1
    localparam int PWM_PERIOD = 255;
    // periods in each on half and each off half of a blink
    localparam int BLINK_PERIODS = 4;

    localparam logic [7:0] MODE_OFF = 8'd0;
    localparam logic [7:0] MODE_STEADY = 8'd1;

endpackage
